//--- include/lock_cfg.svh
`ifndef LOCK_CFG_SVH
`define LOCK_CFG_SVH

`define LOCK_TICKS_PER_SEC   20       // small for simulation
`define LOCK_LOCKOUT_SEC     8'h05    // BCD seconds
`define LOCK_MAX_TRIES       3
`define LOCK_DEFAULT_PW      12'h246

`define LOCK_CLICK_HALF      2        // half-periods in cycles
`define LOCK_SUCCESS_HALF    1
`define LOCK_FAIL_HALF       4

`define LOCK_CLICK_LEN       16       // pattern lengths in cycles
`define LOCK_SUCCESS_LEN     24
`define LOCK_FAIL_LEN        48
`define LOCK_FAIL_GAP_START  16       // silent window of the fail tone
`define LOCK_FAIL_GAP_END    32

`define LOCK_ADDR_PW         4'h0
`define LOCK_ADDR_STATUS     4'h4
`define LOCK_ADDR_FAILS      4'h8

`endif

//--- hdl/lock_pkg.sv
package lock_pkg;

    typedef logic [3:0]  bcd_digit_t;   // one BCD digit
    typedef logic [11:0] bcd3_t;        // three BCD digits, hundreds on top
    typedef logic [2:0]  try_cnt_t;     // failed tries since last reset

    // decoded keypad codes, digits keep their own value
    typedef enum logic [4:0] {
        key_d0          = 5'd0,
        key_d1          = 5'd1,
        key_d2          = 5'd2,
        key_d3          = 5'd3,
        key_d4          = 5'd4,
        key_d5          = 5'd5,
        key_d6          = 5'd6,
        key_d7          = 5'd7,
        key_d8          = 5'd8,
        key_d9          = 5'd9,
        key_enter       = 5'd10,
        key_clear       = 5'd11,
        key_reset_tries = 5'd12,
        key_none        = 5'd31
    } key_code_t;

    typedef enum logic [1:0] {
        st_entry   = 2'd0,   // collecting digits
        st_open    = 2'd1,   // code accepted
        st_lockout = 2'd2    // too many failed tries
    } lock_state_t;

    typedef enum logic [1:0] {
        tone_click   = 2'd0,
        tone_success = 2'd1,
        tone_fail    = 2'd2
    } tone_t;

endpackage

//--- hdl/key_decoder.sv
module key_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic [15:0]         keys,
    output logic                key_valid,
    output lock_pkg::key_code_t key_code
);

    logic [15:0]         keys_q;     // previous keypad sample
    lock_pkg::key_code_t code_next;
    logic                fresh;

    // keypad wiring to key codes
    function automatic lock_pkg::key_code_t decode(input logic [15:0] k);
        lock_pkg::key_code_t code;
        case (k)
            16'h0008: code = lock_pkg::key_d0;
            16'h0080: code = lock_pkg::key_d1;
            16'h0040: code = lock_pkg::key_d2;
            16'h0020: code = lock_pkg::key_d3;
            16'h0800: code = lock_pkg::key_d4;
            16'h0400: code = lock_pkg::key_d5;
            16'h0200: code = lock_pkg::key_d6;
            16'h8000: code = lock_pkg::key_d7;
            16'h0004: code = lock_pkg::key_d8;
            16'h2000: code = lock_pkg::key_d9;
            16'h0001: code = lock_pkg::key_enter;
            16'h1000: code = lock_pkg::key_clear;
            16'h0100: code = lock_pkg::key_reset_tries;
            default:  code = lock_pkg::key_none;    // idle, multi-hot or unused line
        endcase
        return code;
    endfunction

    assign code_next = decode(keys);
    assign fresh     = (keys != keys_q) && (code_next != lock_pkg::key_none);

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_q    <= '0;
            key_valid <= 1'b0;
            key_code  <= lock_pkg::key_none;
        end else begin
            keys_q    <= keys;    // zero and multi-hot are remembered too
            key_valid <= fresh;
            if (fresh) begin
                key_code <= code_next;
            end
        end
    end

endmodule

//--- hdl/lock_ctrl.sv
`include "lock_cfg.svh"

module lock_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  lock_pkg::key_code_t   key_code,
    input  lock_pkg::bcd3_t       password,
    input  logic                  lockout_done,
    input  lock_pkg::bcd3_t       remaining,
    output lock_pkg::bcd3_t       display,
    output lock_pkg::lock_state_t state,
    output lock_pkg::try_cnt_t    tries,
    output logic                  fail_event,
    output logic                  lockout_start,
    output logic                  locked_out,
    output logic                  tone_start,
    output lock_pkg::tone_t       tone_sel
);

    localparam lock_pkg::bcd3_t blank_code = 12'hFFF;
    localparam lock_pkg::bcd3_t open_code  = 12'h0AE;   // reads as "0PE"

    lock_pkg::bcd3_t    entry;        // newest digit in the low nibble
    logic [1:0]         digit_cnt;
    lock_pkg::try_cnt_t tries_inc;
    logic               key_entry;
    logic               key_open;
    logic               take_digit;
    logic               take_clear;
    logic               take_reset;
    logic               enter_full;
    logic               good_try;
    logic               bad_try;

    assign key_entry  = key_valid && (state == lock_pkg::st_entry);
    assign key_open   = key_valid && (state == lock_pkg::st_open);
    assign take_digit = key_entry && (key_code <= lock_pkg::key_d9) && (digit_cnt != 2'd3);
    assign take_clear = (key_entry || key_open) && (key_code == lock_pkg::key_clear);
    assign take_reset = (key_entry || key_open) && (key_code == lock_pkg::key_reset_tries);
    assign enter_full = key_entry && (key_code == lock_pkg::key_enter) && (digit_cnt == 2'd3);
    assign good_try   = enter_full && (entry == password);
    assign bad_try    = enter_full && (entry != password);
    assign tries_inc  = tries + 3'd1;

    // event pulses leave in the same cycle as the decision
    assign fail_event    = bad_try;
    assign lockout_start = bad_try && (tries_inc == lock_pkg::try_cnt_t'(`LOCK_MAX_TRIES));
    assign tone_start    = take_digit || take_clear || enter_full;
    assign locked_out    = (state == lock_pkg::st_lockout);

    always_comb begin
        if (good_try) begin
            tone_sel = lock_pkg::tone_success;
        end else if (bad_try) begin
            tone_sel = lock_pkg::tone_fail;
        end else begin
            tone_sel = lock_pkg::tone_click;
        end
    end

    always_comb begin
        case (state)
            lock_pkg::st_open:    display = open_code;
            lock_pkg::st_lockout: display = remaining;    // countdown seconds
            default:              display = entry;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= lock_pkg::st_entry;
            entry     <= blank_code;
            digit_cnt <= 2'd0;
            tries     <= '0;
        end else begin
            if (take_digit) begin
                entry     <= {entry[7:0], lock_pkg::bcd_digit_t'(key_code)};
                digit_cnt <= digit_cnt + 2'd1;
            end
            if (take_clear || take_reset || enter_full) begin
                entry     <= blank_code;
                digit_cnt <= 2'd0;
            end
            if (take_reset) begin
                tries <= '0;
            end
            case (state)
                lock_pkg::st_entry: begin
                    if (good_try) begin
                        state <= lock_pkg::st_open;
                    end else if (lockout_start) begin
                        state <= lock_pkg::st_lockout;
                        tries <= '0;
                    end else if (bad_try) begin
                        tries <= tries_inc;
                    end
                end
                lock_pkg::st_open: begin
                    if (take_clear) begin
                        state <= lock_pkg::st_entry;    // relock
                    end
                end
                default: begin
                    if (lockout_done) begin
                        state <= lock_pkg::st_entry;
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/lockout_timer.sv
`include "lock_cfg.svh"

module lockout_timer (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    output lock_pkg::bcd3_t remaining,
    output logic            done
);

    localparam int presc_w = $clog2(`LOCK_TICKS_PER_SEC);

    logic [presc_w-1:0] presc;    // cycles within the current second
    logic               tick;

    // BCD decrement, borrow ripples upward
    function automatic lock_pkg::bcd3_t bcd_dec(input lock_pkg::bcd3_t v);
        lock_pkg::bcd3_t r;
        r = v;
        if (v[3:0] != 4'd0) begin
            r[3:0] = v[3:0] - 4'd1;
        end else begin
            r[3:0] = 4'd9;
            if (v[7:4] != 4'd0) begin
                r[7:4] = v[7:4] - 4'd1;
            end else begin
                r[7:4]  = 4'd9;
                r[11:8] = v[11:8] - 4'd1;
            end
        end
        return r;
    endfunction

    assign tick = (presc == presc_w'(`LOCK_TICKS_PER_SEC - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            presc     <= '0;
            remaining <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                remaining <= {4'h0, 8'(`LOCK_LOCKOUT_SEC)};
                presc     <= '0;
            end else if (remaining != '0) begin    // idle at zero
                if (tick) begin
                    presc     <= '0;
                    remaining <= bcd_dec(remaining);
                    done      <= (remaining == 12'h001);
                end else begin
                    presc <= presc + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/buzzer_gen.sv
`include "lock_cfg.svh"

module buzzer_gen (
    input  logic            clk,
    input  logic            rst,
    input  logic            tone_start,
    input  lock_pkg::tone_t tone_sel,
    output logic            buzzer
);

    lock_pkg::tone_t sel_q;      // pattern being played
    logic            active;
    logic            level;      // square wave before gating
    logic [7:0]      len_cnt;
    logic [7:0]      half_cnt;
    logic [7:0]      len_max;
    logic [7:0]      half_max;
    logic            in_gap;

    always_comb begin
        case (sel_q)
            lock_pkg::tone_success: begin
                half_max = 8'(`LOCK_SUCCESS_HALF - 1);
                len_max  = 8'(`LOCK_SUCCESS_LEN - 1);
            end
            lock_pkg::tone_fail: begin
                half_max = 8'(`LOCK_FAIL_HALF - 1);
                len_max  = 8'(`LOCK_FAIL_LEN - 1);
            end
            default: begin
                half_max = 8'(`LOCK_CLICK_HALF - 1);
                len_max  = 8'(`LOCK_CLICK_LEN - 1);
            end
        endcase
    end

    // fail tone is broken in the middle
    assign in_gap = (sel_q == lock_pkg::tone_fail) &&
                    (len_cnt >= 8'(`LOCK_FAIL_GAP_START)) &&
                    (len_cnt < 8'(`LOCK_FAIL_GAP_END));
    assign buzzer = active && level && !in_gap;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            level    <= 1'b0;
            sel_q    <= lock_pkg::tone_click;
            len_cnt  <= '0;
            half_cnt <= '0;
        end else if (tone_start) begin
            active   <= 1'b1;    // restart, even mid-pattern
            level    <= 1'b1;
            sel_q    <= tone_sel;
            len_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (len_cnt == len_max) begin
                active <= 1'b0;
                level  <= 1'b0;
            end else begin
                len_cnt <= len_cnt + 8'd1;
            end
            if (half_cnt == half_max) begin
                half_cnt <= '0;
                level    <= ~level;
            end else begin
                half_cnt <= half_cnt + 8'd1;
            end
        end
    end

endmodule

//--- hdl/apb_regs.sv
`include "lock_cfg.svh"

module apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [3:0]            paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  lock_pkg::lock_state_t state,
    input  lock_pkg::try_cnt_t    tries,
    input  logic                  fail_event,
    output lock_pkg::bcd3_t       password
);

    logic [7:0] fails;    // saturating total of wrong codes
    logic       access;
    logic       wr_en;
    logic       hit_pw;
    logic       hit_status;
    logic       hit_fails;

    assign access     = psel && penable;
    assign wr_en      = access && pwrite;
    assign hit_pw     = (paddr == `LOCK_ADDR_PW);
    assign hit_status = (paddr == `LOCK_ADDR_STATUS);
    assign hit_fails  = (paddr == `LOCK_ADDR_FAILS);

    assign pready  = 1'b1;    // no wait states
    assign pslverr = access && !(hit_pw || hit_status || hit_fails);

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_pw) begin
                prdata = {20'h0, password};
            end else if (hit_status) begin
                prdata = {27'h0, tries, state};
            end else if (hit_fails) begin
                prdata = {24'h0, fails};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            password <= `LOCK_DEFAULT_PW;
            fails    <= '0;
        end else begin
            if (wr_en && hit_pw) begin
                password <= pwdata[11:0];
            end
            if (wr_en && hit_fails) begin
                fails <= '0;    // any write clears
            end else if (fail_event && (fails != 8'hFF)) begin
                fails <= fails + 8'd1;
            end
        end
    end

endmodule

//--- hdl/lock_top.sv
module lock_top (
    input  logic            clk,
    input  logic            rst,
    input  logic [15:0]     keys,
    input  logic [3:0]      paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output lock_pkg::bcd3_t display,
    output logic            buzzer,
    output logic            locked_out
);

    logic                  key_valid;
    lock_pkg::key_code_t   key_code;
    lock_pkg::bcd3_t       password;
    lock_pkg::bcd3_t       remaining;       // lockout countdown
    logic                  lockout_start;
    logic                  lockout_done;
    lock_pkg::lock_state_t state;
    lock_pkg::try_cnt_t    tries;
    logic                  fail_event;
    logic                  tone_start;
    lock_pkg::tone_t       tone_sel;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    lock_ctrl u_lock_ctrl (
        .clk           (clk),
        .rst           (rst),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .password      (password),
        .lockout_done  (lockout_done),
        .remaining     (remaining),
        .display       (display),
        .state         (state),
        .tries         (tries),
        .fail_event    (fail_event),
        .lockout_start (lockout_start),
        .locked_out    (locked_out),
        .tone_start    (tone_start),
        .tone_sel      (tone_sel)
    );

    lockout_timer u_lockout_timer (
        .clk       (clk),
        .rst       (rst),
        .start     (lockout_start),
        .remaining (remaining),
        .done      (lockout_done)
    );

    buzzer_gen u_buzzer_gen (
        .clk        (clk),
        .rst        (rst),
        .tone_start (tone_start),
        .tone_sel   (tone_sel),
        .buzzer     (buzzer)
    );

    apb_regs u_apb_regs (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .state      (state),
        .tries      (tries),
        .fail_event (fail_event),
        .password   (password)
    );

endmodule

//--- verif/lock_checker.sv
`include "lock_cfg.svh"

module lock_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  key_valid,
    input logic                  psel,
    input logic                  pready,
    input logic                  buzzer,
    input logic                  tone_start,
    input lock_pkg::lock_state_t state,
    input lock_pkg::bcd3_t       display
);
    timeunit 1ns;
    timeprecision 100ps;

    key_pulse: assert property (@(posedge clk) disable iff (rst)
        key_valid |=> !key_valid)
        else $error("key_valid high for two cycles in a row");

    no_wait: assert property (@(posedge clk) disable iff (rst)
        psel |-> pready)
        else $error("pready low during an APB transfer");

    // no pattern outlives the fail tone
    quiet_buzzer: assert property (@(posedge clk) disable iff (rst)
        (!tone_start) [*`LOCK_FAIL_LEN] |=> !buzzer)
        else $error("buzzer high with no pattern active");

    // countdown digits stay in 0..9
    lockout_bcd: assert property (@(posedge clk) disable iff (rst)
        (state == lock_pkg::st_lockout) |->
            (display[3:0] <= 4'd9 && display[7:4] <= 4'd9 && display[11:8] <= 4'd9))
        else $error("lockout display is not BCD");

endmodule

bind lock_top lock_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .key_valid  (key_valid),
    .psel       (psel),
    .pready     (pready),
    .buzzer     (buzzer),
    .tone_start (tone_start),
    .state      (state),
    .display    (display)
);

//--- verif/lock_tb.sv
`include "lock_cfg.svh"

module lock_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int k_enter = 10;
    localparam int k_clear = 11;
    localparam int k_reset = 12;
    localparam int num_ops = 400;
    localparam int lockout_limit =
        ((`LOCK_LOCKOUT_SEC >> 4) * 10 + (`LOCK_LOCKOUT_SEC & 8'hF)) * `LOCK_TICKS_PER_SEC + 4;

    // keypad line per key: digits 0..9, then enter, clear, reset tries
    localparam logic [15:0] key_map [0:12] = '{
        16'h0008, 16'h0080, 16'h0040, 16'h0020, 16'h0800, 16'h0400, 16'h0200,
        16'h8000, 16'h0004, 16'h2000, 16'h0001, 16'h1000, 16'h0100
    };

    logic            clk;
    logic            rst;
    logic [15:0]     keys;
    logic [3:0]      paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic            pslverr;
    lock_pkg::bcd3_t display;
    logic            buzzer;
    logic            locked_out;

    logic [31:0]           lcg_state;
    lock_pkg::bcd3_t       m_entry;    // reference model
    int                    m_cnt;
    int                    m_tries;
    lock_pkg::lock_state_t m_state;
    lock_pkg::bcd3_t       m_pw;
    int                    m_fails;

    lock_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % n;
    endfunction

    function automatic lock_pkg::bcd3_t random_code();
        lock_pkg::bcd3_t c;
        c[11:8] = 4'(rand_below(10));
        c[7:4]  = 4'(rand_below(10));
        c[3:0]  = 4'(rand_below(10));
        return c;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic error_stop(input string msg);
        $display("[ERROR] %s", msg);
        $display("Simulation FAILED");
        $fatal(1, "%s", msg);
    endtask

    function automatic lock_pkg::bcd3_t exp_display();
        if (m_state == lock_pkg::st_open)
            return 12'h0AE;    // "0PE"
        return m_entry;
    endfunction

    task automatic model_key(input int k, output bit tone);
        tone = 1'b0;
        if (m_state == lock_pkg::st_entry) begin
            if (k <= 9 && m_cnt < 3) begin
                m_entry = {m_entry[7:0], 4'(k)};    // newest digit low
                m_cnt++;
                tone = 1'b1;
            end else if (k == k_enter && m_cnt == 3) begin
                tone = 1'b1;
                if (m_entry == m_pw) begin
                    m_state = lock_pkg::st_open;
                end else begin
                    m_tries++;
                    if (m_fails < 255)
                        m_fails++;
                    if (m_tries == `LOCK_MAX_TRIES) begin
                        m_tries = 0;
                        m_state = lock_pkg::st_lockout;
                    end
                end
                m_entry = 12'hFFF;
                m_cnt   = 0;
            end else if (k == k_clear || k == k_reset) begin
                tone    = (k == k_clear);
                m_entry = 12'hFFF;
                m_cnt   = 0;
                if (k == k_reset)
                    m_tries = 0;
            end
        end else if (m_state == lock_pkg::st_open) begin
            if (k == k_clear) begin
                tone    = 1'b1;
                m_state = lock_pkg::st_entry;    // relock
            end else if (k == k_reset) begin
                m_tries = 0;
            end
        end
    endtask

    // hold 3 cycles, release 3 cycles, watch the buzzer meanwhile
    task automatic press(input int k, input bit tone_exp);
        bit seen_hi;
        bit seen_lo;
        int i;
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        @(posedge clk);
        keys <= key_map[k];
        for (i = 1; i <= 6; i++) begin
            @(posedge clk);
            if (i == 3)
                keys <= '0;
            @(negedge clk);
            if (buzzer)
                seen_hi = 1'b1;
            else if (seen_hi)
                seen_lo = 1'b1;    // low after high
        end
        if (tone_exp && !(seen_hi && seen_lo))
            error_stop($sformatf("buzzer did not toggle after key %0d", k));
    endtask

    task automatic do_key(input int k);
        bit tone;
        model_key(k, tone);
        press(k, tone);
        check($sformatf("locked_out after key %0d", k), m_state == lock_pkg::st_lockout,
              locked_out);
        if (m_state != lock_pkg::st_lockout)
            check($sformatf("display after key %0d", k), exp_display(), display);
    endtask

    task automatic apb_xfer(input logic [3:0] addr, input bit wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int wait_cnt;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;    // access phase
        wait_cnt = 0;
        @(negedge clk);
        while (!pready) begin
            wait_cnt++;
            if (wait_cnt > 8)
                error_stop("timeout waiting for pready in the APB access phase");
            @(posedge clk);
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        @(negedge clk);
    endtask

    task automatic read_check(input logic [3:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(addr, 1'b0, '0, rdata, err);
        check($sformatf("pslverr on read of %0h", addr),
              !(addr == `LOCK_ADDR_PW || addr == `LOCK_ADDR_STATUS || addr == `LOCK_ADDR_FAILS),
              err);
        case (addr)
            `LOCK_ADDR_PW:     check("PW read", {20'h0, m_pw}, rdata);
            `LOCK_ADDR_STATUS: check("STATUS read", {27'h0, 3'(m_tries), m_state}, rdata);
            `LOCK_ADDR_FAILS:  check("FAILS read", m_fails, rdata);
            default: ;
        endcase
    endtask

    task automatic write_op();
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic        err;
        int          sel;
        sel   = rand_below(3);
        wdata = {20'(rand_below(32'h10000)), random_code()};    // junk above bit 11
        if (sel == 0) begin
            apb_xfer(`LOCK_ADDR_PW, 1'b1, wdata, rdata, err);
            check("pslverr on PW write", 0, err);
            m_pw = wdata[11:0];
            read_check(`LOCK_ADDR_PW);
        end else if (sel == 1) begin
            apb_xfer(`LOCK_ADDR_FAILS, 1'b1, wdata, rdata, err);
            check("pslverr on FAILS write", 0, err);
            m_fails = 0;
            read_check(`LOCK_ADDR_FAILS);
        end else begin
            apb_xfer(4'(rand_below(8) * 2 + 1), 1'b1, wdata, rdata, err);    // odd, unmapped
            check("pslverr on unmapped write", 1, err);
        end
    endtask

    task automatic full_code(input bit use_pw);
        lock_pkg::bcd3_t code;
        code = use_pw ? m_pw : random_code();
        do_key(k_clear);
        do_key(code[11:8]);
        do_key(code[7:4]);
        do_key(code[3:0]);
        do_key(k_enter);
        read_check(`LOCK_ADDR_STATUS);
        read_check(`LOCK_ADDR_FAILS);
    endtask

    task automatic run_lockout();
        lock_pkg::bcd3_t prev;
        int              cycles;
        check("lockout start display", {4'h0, 8'(`LOCK_LOCKOUT_SEC)}, display);
        prev   = display;
        cycles = 0;
        while (locked_out) begin
            if (cycles > lockout_limit)
                error_stop("timeout waiting for locked_out to fall");
            if (display >= 12'h002 && rand_below(4) == 0) begin
                do_key(rand_below(13));    // must be dropped
                cycles += 7;
            end else begin
                @(posedge clk);
                @(negedge clk);
                cycles++;
            end
            if (locked_out && display > prev)
                error_stop("lockout countdown went up");
            prev = display;
        end
        m_state = lock_pkg::st_entry;
        check("display after lockout", 12'hFFF, display);
        read_check(`LOCK_ADDR_STATUS);
    endtask

    initial begin
        int op;
        int n;
        lcg_state = 32'd39500;
        rst       = 1'b1;
        keys      = '0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        m_entry   = 12'hFFF;
        m_cnt     = 0;
        m_tries   = 0;
        m_state   = lock_pkg::st_entry;
        m_pw      = `LOCK_DEFAULT_PW;
        m_fails   = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("reset display", 12'hFFF, display);
        check("reset buzzer", 0, buzzer);
        check("reset locked_out", 0, locked_out);
        check("reset pslverr", 0, pslverr);
        read_check(`LOCK_ADDR_PW);
        for (n = 0; n < num_ops; n++) begin
            op = rand_below(16);
            if (op < 5)
                do_key(rand_below(10));
            else if (op == 5)
                do_key(k_enter);
            else if (op == 6)
                do_key(k_clear);
            else if (op == 7)
                do_key(k_reset);
            else if (op < 13)
                full_code(op < 11);
            else if (op == 13)
                write_op();
            else if (rand_below(4) == 3)
                read_check(4'(rand_below(16)));
            else
                read_check(4'(rand_below(3) * 4));
            if (m_state == lock_pkg::st_lockout)
                run_lockout();
            if (op >= 8 && op < 13) begin
                repeat (`LOCK_FAIL_LEN + 4) @(posedge clk);    // longest pattern
                @(negedge clk);
                check("buzzer idle", 0, buzzer);
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- lock_top.f
+incdir+include
hdl/lock_pkg.sv
hdl/key_decoder.sv
hdl/lock_ctrl.sv
hdl/lockout_timer.sv
hdl/buzzer_gen.sv
hdl/apb_regs.sv
hdl/lock_top.sv
verif/lock_checker.sv
verif/lock_tb.sv

//--- Bender.yml
package:
  name: lock_top

sources:
  - include_dirs:
      - include
    files:
      - hdl/lock_pkg.sv
      - hdl/key_decoder.sv
      - hdl/lock_ctrl.sv
      - hdl/lockout_timer.sv
      - hdl/buzzer_gen.sv
      - hdl/apb_regs.sv
      - hdl/lock_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/lock_checker.sv
      - verif/lock_tb.sv
